//--- compile.f
src/ahb_apb_pkg.sv
src/apb_bus_if.sv
src/apb_addr_map.sv
src/apb_master_fsm.sv
src/apb_slave_mux.sv
src/ahb_apb_bridge.sv
bench/apb_slave_model.sv
bench/tb_ahb_apb_bridge.sv

//--- bench/tb_ahb_apb_bridge.sv
// AHB to APB bridge testbench
module tb_ahb_apb_bridge;

  localparam int                 NUM_SLAVES = 4;
  localparam ahb_apb_pkg::addr_t BASE_ADDR  = 32'h0080_0000;
  localparam int                 SLOT_BITS  = 16;
  localparam int                 N_DECODE   = 24;
  localparam int                 N_RW       = 32;
  localparam int                 N_SEQ      = 16;
  localparam int                 N_IGNORE   = 20;
  localparam int                 N_XFERS    = N_DECODE + 2 * N_RW + N_SEQ + N_IGNORE;
  localparam int                 MAX_CYCLES = N_XFERS * 8 + 50;

  logic                                hclk;
  logic                                hreset_n;
  logic                                hsel;
  ahb_apb_pkg::addr_t                  haddr;
  ahb_apb_pkg::htrans_e                htrans;
  logic                                hwrite;
  ahb_apb_pkg::data_t                  hwdata;
  ahb_apb_pkg::data_t                  hrdata;
  logic                                hready;
  ahb_apb_pkg::addr_t                  paddr;
  logic                                pwrite;
  logic                                penable;
  ahb_apb_pkg::data_t                  pwdata;
  logic [NUM_SLAVES-1:0]               psel;
  logic [NUM_SLAVES-1:0]               pready;
  ahb_apb_pkg::data_t [NUM_SLAVES-1:0] prdata;

  // Reference memory by byte address
  ahb_apb_pkg::data_t ref_mem [ahb_apb_pkg::addr_t];
  // Read data the bridge holds across writes
  ahb_apb_pkg::data_t last_rdata = '0;
  int                 errors     = 0;
  int                 test_start = 0;
  int                 cycles     = 0;
  int                 rw_slot [N_RW];
  int                 rw_word [N_RW];

  ahb_apb_bridge #(
    .NUM_SLAVES (NUM_SLAVES),
    .BASE_ADDR  (BASE_ADDR),
    .SLOT_BITS  (SLOT_BITS)
  ) DUT (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .hsel     (hsel),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hwdata   (hwdata),
    .hrdata   (hrdata),
    .hready   (hready),
    .paddr    (paddr),
    .pwrite   (pwrite),
    .penable  (penable),
    .pwdata   (pwdata),
    .psel     (psel),
    .pready   (pready),
    .prdata   (prdata)
  );

  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
    apb_slave_model u_slave (
      .hclk     (hclk),
      .hreset_n (hreset_n),
      .psel     (psel[s]),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .pready   (pready[s]),
      .prdata   (prdata[s])
    );
  end

  initial begin
    hclk = 1'b0;
    forever #4 hclk = ~hclk;
  end

  // Run limit
  always @(posedge hclk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic report_fail(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    errors++;
    $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic close_test(input string name);
    if (errors == test_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  function automatic ahb_apb_pkg::addr_t mapped_addr(input int slot, input int word);
    return BASE_ADDR + (ahb_apb_pkg::addr_t'(slot) << SLOT_BITS)
           + ahb_apb_pkg::addr_t'(word * 4);
  endfunction

  // One full transfer with setup, access and completion checks
  task automatic run_transfer(input int slot, input int word, input logic wr,
                              input ahb_apb_pkg::data_t wdata);
    ahb_apb_pkg::addr_t    addr;
    ahb_apb_pkg::data_t    expected;
    logic [NUM_SLAVES-1:0] exp_sel;
    int                    waits;

    addr          = mapped_addr(slot, word);
    exp_sel       = '0;
    exp_sel[slot] = 1'b1;
    waits         = 0;
    hsel   = 1'b1;
    htrans = ($urandom_range(0, 1) == 0) ? ahb_apb_pkg::NONSEQ : ahb_apb_pkg::SEQ;
    haddr  = addr;
    hwrite = wr;
    hwdata = wdata;
    @(posedge hclk);
    #1;
    hsel   = 1'b0;
    htrans = ahb_apb_pkg::IDLE;
    // Setup cycle
    if (psel !== exp_sel) report_fail("psel", exp_sel, psel);
    if (paddr !== addr) report_fail("paddr", addr, paddr);
    if (pwrite !== wr) report_fail("pwrite", wr, pwrite);
    if (pwdata !== wdata) report_fail("pwdata", wdata, pwdata);
    if (penable !== 1'b0) report_fail("penable", 1'b0, penable);
    if (hready !== 1'b0) report_fail("hready", 1'b0, hready);
    @(posedge hclk);
    #1;
    if (penable !== 1'b1) report_fail("penable", 1'b1, penable);
    if (hready !== 1'b0) report_fail("hready", 1'b0, hready);
    // Access stretched by the peripheral
    while (pready[slot] !== 1'b1) begin
      @(posedge hclk);
      #1;
      waits++;
      if (hready !== 1'b0) report_fail("hready", 1'b0, hready);
    end
    if (waits > 3) begin
      errors++;
      $display("Access at %0t lasted %0d wait cycles, more than the peripheral adds",
               $time, waits);
    end
    @(posedge hclk);
    #1;
    if (hready !== 1'b1) report_fail("hready", 1'b1, hready);
    if (psel !== '0) report_fail("psel", '0, psel);
    if (penable !== 1'b0) report_fail("penable", 1'b0, penable);
    if (wr) begin
      ref_mem[addr] = wdata;
      if (hrdata !== last_rdata) report_fail("hrdata", last_rdata, hrdata);
    end else begin
      expected = ref_mem.exists(addr) ? ref_mem[addr] : '0;
      if (hrdata !== expected) report_fail("hrdata", expected, hrdata);
      last_rdata = expected;
    end
  endtask

  // A request the bridge must not accept
  task automatic ignored_transfer(input int kind);
    hsel   = 1'b1;
    htrans = ahb_apb_pkg::NONSEQ;
    haddr  = mapped_addr($urandom_range(0, NUM_SLAVES - 1), $urandom_range(0, 15));
    hwrite = 1'($urandom_range(0, 1));
    case (kind)
      0: htrans = ahb_apb_pkg::IDLE;
      1: htrans = ahb_apb_pkg::BUSY;
      2: hsel = 1'b0;
      3: haddr = BASE_ADDR - ahb_apb_pkg::addr_t'(4 * (1 + $urandom_range(0, 255)));
      default: haddr = mapped_addr(NUM_SLAVES + $urandom_range(0, 7), $urandom_range(0, 15));
    endcase
    @(posedge hclk);
    #1;
    if (psel !== '0) report_fail("psel", '0, psel);
    if (hready !== 1'b1) report_fail("hready", 1'b1, hready);
    if (penable !== 1'b0) report_fail("penable", 1'b0, penable);
    hsel   = 1'b0;
    htrans = ahb_apb_pkg::IDLE;
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    void'($urandom(32'h12a98110));
    hreset_n = 1'b0;
    hsel     = 1'b0;
    haddr    = '0;
    htrans   = ahb_apb_pkg::IDLE;
    hwrite   = 1'b0;
    hwdata   = '0;
    repeat (3) @(posedge hclk);
    #1;
    hreset_n = 1'b1;

    if (psel !== '0) report_fail("psel", '0, psel);
    if (penable !== 1'b0) report_fail("penable", 1'b0, penable);
    if (hready !== 1'b1) report_fail("hready", 1'b1, hready);
    if (hrdata !== '0) report_fail("hrdata", '0, hrdata);
    if (paddr !== '0) report_fail("paddr", '0, paddr);
    if (pwrite !== 1'b0) report_fail("pwrite", 1'b0, pwrite);
    close_test("Test 1 reset state");

    for (int i = 0; i < N_DECODE; i++) begin
      run_transfer($urandom_range(0, NUM_SLAVES - 1), $urandom_range(0, 15),
                   1'($urandom_range(0, 1)), $urandom);
    end
    close_test("Test 2 address decode");

    // Writes spread over every slave and then read back
    for (int i = 0; i < N_RW; i++) begin
      rw_slot[i] = i % NUM_SLAVES;
      rw_word[i] = $urandom_range(0, 15);
      run_transfer(rw_slot[i], rw_word[i], 1'b1, $urandom);
    end
    for (int i = 0; i < N_RW; i++) begin
      run_transfer(rw_slot[i], rw_word[i], 1'b0, $urandom);
    end
    close_test("Test 3 write then read");

    for (int i = 0; i < N_SEQ; i++) begin
      run_transfer(i % NUM_SLAVES, $urandom_range(0, 15), 1'($urandom_range(0, 1)), $urandom);
    end
    close_test("Test 4 sequencing and wait states");

    for (int i = 0; i < N_IGNORE; i++) begin
      ignored_transfer(i % 5);
    end
    close_test("Test 5 ignored transfers");

    $display("5 tests run, %0d errors, %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- bench/apb_slave_model.sv
// Behavioral APB peripheral
module apb_slave_model #(
  parameter int WORDS = 16
) (
  input  logic               hclk,
  input  logic               hreset_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  ahb_apb_pkg::addr_t paddr,
  input  ahb_apb_pkg::data_t pwdata,
  output logic               pready,
  output ahb_apb_pkg::data_t prdata
);

  ahb_apb_pkg::data_t       mem [WORDS];
  logic [1:0]               wait_target;
  logic [1:0]               wait_count;
  logic [$clog2(WORDS)-1:0] word;

  // Word aligned, the in-slot offset picks the memory row
  assign word = paddr[$clog2(WORDS)+1:2];

  // Ready once the chosen number of wait cycles has gone by
  assign pready = psel && penable && (wait_count == wait_target);
  assign prdata = psel ? mem[word] : '0;

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      wait_target <= '0;
      wait_count  <= '0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (psel && !penable) begin
        // Setup phase, pick 0 to 3 wait cycles for this access
        wait_target <= 2'($urandom_range(0, 3));
        wait_count  <= '0;
      end else if (psel && penable) begin
        if (pready) begin
          if (pwrite) begin
            mem[word] <= pwdata;
          end
        end else begin
          wait_count <= wait_count + 2'd1;
        end
      end
    end
  end

endmodule

//--- src/ahb_apb_bridge.sv
// AHB to APB bridge top level
module ahb_apb_bridge #(
  parameter int                 NUM_SLAVES = ahb_apb_pkg::DEF_NUM_SLAVES,
  parameter ahb_apb_pkg::addr_t BASE_ADDR  = ahb_apb_pkg::DEF_BASE_ADDR,
  parameter int                 SLOT_BITS  = ahb_apb_pkg::DEF_SLOT_BITS
) (
  // AHB slave side
  input  logic                                hclk,
  input  logic                                hreset_n,
  input  logic                                hsel,
  input  ahb_apb_pkg::addr_t                  haddr,
  input  ahb_apb_pkg::htrans_e                htrans,
  input  logic                                hwrite,
  input  ahb_apb_pkg::data_t                  hwdata,
  output ahb_apb_pkg::data_t                  hrdata,
  output logic                                hready,

  // APB side, shared by all peripherals
  output ahb_apb_pkg::addr_t                  paddr,
  output logic                                pwrite,
  output logic                                penable,
  output ahb_apb_pkg::data_t                  pwdata,

  // APB side, one lane per peripheral
  output logic [NUM_SLAVES-1:0]               psel,
  input  logic [NUM_SLAVES-1:0]               pready,
  input  ahb_apb_pkg::data_t [NUM_SLAVES-1:0] prdata
);

  logic                    map_hit;
  ahb_apb_pkg::slave_idx_t map_idx;

  apb_bus_if #(
    .NUM_SLAVES (NUM_SLAVES)
  ) apb_bus ();

  // ------------------------------
  // Address decode
  // ------------------------------
  apb_addr_map #(
    .NUM_SLAVES (NUM_SLAVES),
    .BASE_ADDR  (BASE_ADDR),
    .SLOT_BITS  (SLOT_BITS)
  ) u_addr_map (
    .haddr (haddr),
    .hit   (map_hit),
    .idx   (map_idx)
  );

  // ------------------------------
  // Sequencer
  // ------------------------------
  apb_master_fsm u_master_fsm (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .hsel     (hsel),
    .hwrite   (hwrite),
    .htrans   (htrans),
    .haddr    (haddr),
    .hit      (map_hit),
    .idx      (map_idx),
    .hready   (hready),
    .hrdata   (hrdata),
    .bus      (apb_bus.master)
  );

  // ------------------------------
  // Peripheral fan-out
  // ------------------------------
  apb_slave_mux #(
    .NUM_SLAVES (NUM_SLAVES)
  ) u_slave_mux (
    .hclk      (hclk),
    .bus       (apb_bus.fanout),
    .psel      (psel),
    .pready_in (pready),
    .prdata_in (prdata)
  );

  // Shared APB request lines
  assign paddr   = apb_bus.paddr;
  assign pwrite  = apb_bus.pwrite;
  assign penable = apb_bus.penable;

  // Write data is not registered and relies on hwdata holding during wait states
  assign pwdata  = hwdata;

endmodule

//--- src/apb_slave_mux.sv
// APB select decode and response fan-in
module apb_slave_mux #(
  parameter int NUM_SLAVES = ahb_apb_pkg::DEF_NUM_SLAVES
) (
  input  logic                                hclk,
  apb_bus_if.fanout                           bus,
  output logic [NUM_SLAVES-1:0]               psel,
  input  logic [NUM_SLAVES-1:0]               pready_in,
  input  ahb_apb_pkg::data_t [NUM_SLAVES-1:0] prdata_in
);

  // ------------------------------
  // One-hot select
  // ------------------------------
  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      psel[i] = bus.lane_valid && (bus.sel_idx == ahb_apb_pkg::slave_idx_t'(i));
    end
  end

  // ------------------------------
  // Response fan-in
  // ------------------------------
  // Unselected lanes are masked to zero, so an OR tree is enough
  always_comb begin
    ahb_apb_pkg::data_t rdata_acc;
    logic               ready_acc;

    rdata_acc = '0;
    ready_acc = 1'b0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (psel[i]) begin
        rdata_acc = rdata_acc | prdata_in[i];
        ready_acc = ready_acc | pready_in[i];
      end
    end
    bus.prdata = rdata_acc;
    bus.pready = ready_acc;
  end

  // At most one peripheral is ever selected
  a_psel_onehot: assert property (
    @(posedge hclk) $onehot0(psel)
  );

endmodule

//--- src/apb_master_fsm.sv
// AHB capture and APB sequencer
module apb_master_fsm (
  input  logic                    hclk,
  input  logic                    hreset_n,
  input  logic                    hsel,
  input  logic                    hwrite,
  input  ahb_apb_pkg::htrans_e    htrans,
  input  ahb_apb_pkg::addr_t      haddr,
  input  logic                    hit,
  input  ahb_apb_pkg::slave_idx_t idx,
  output logic                    hready,
  output ahb_apb_pkg::data_t      hrdata,
  apb_bus_if.master               bus
);

  ahb_apb_pkg::apb_state_e state;
  logic                    active_trans;
  logic                    accept;
  logic                    done;

  // ------------------------------
  // Transfer qualification
  // ------------------------------
  // Only NONSEQ and SEQ carry a real transfer
  assign active_trans = (htrans == ahb_apb_pkg::NONSEQ) ||
                        (htrans == ahb_apb_pkg::SEQ);

  // Unmapped addresses are never accepted, so the bus never stalls on them
  assign accept = (state == ahb_apb_pkg::ST_IDLE) && hsel && active_trans && hit;

  // Access phase ends on the selected peripheral's pready
  assign done = (state == ahb_apb_pkg::ST_ACCESS) && bus.pready;

  // Wait states are inserted whenever a transfer is in flight
  assign hready = (state == ahb_apb_pkg::ST_IDLE);

  // ------------------------------
  // Sequencer
  // ------------------------------
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      state         <= ahb_apb_pkg::ST_IDLE;
      bus.paddr     <= '0;
      bus.pwrite    <= 1'b0;
      bus.penable   <= 1'b0;
      bus.sel_idx   <= '0;
      bus.sel_valid <= 1'b0;
      hrdata        <= '0;
    end else begin
      case (state)
        ahb_apb_pkg::ST_IDLE: begin
          if (accept) begin
            state         <= ahb_apb_pkg::ST_SETUP;
            bus.paddr     <= haddr;
            bus.pwrite    <= hwrite;
            bus.sel_idx   <= idx;
            bus.sel_valid <= 1'b1;
          end
        end

        ahb_apb_pkg::ST_SETUP: begin
          state       <= ahb_apb_pkg::ST_ACCESS;
          bus.penable <= 1'b1;
        end

        ahb_apb_pkg::ST_ACCESS: begin
          // Everything holds while the peripheral stretches access
          if (done) begin
            state         <= ahb_apb_pkg::ST_IDLE;
            bus.penable   <= 1'b0;
            bus.sel_valid <= 1'b0;
            if (!bus.pwrite) begin
              hrdata <= bus.prdata;
            end
          end
        end

        default: begin
          state         <= ahb_apb_pkg::ST_IDLE;
          bus.penable   <= 1'b0;
          bus.sel_valid <= 1'b0;
        end
      endcase
    end
  end

  // ------------------------------
  // Protocol checks
  // ------------------------------
  a_penable_in_access: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    bus.penable |-> (state == ahb_apb_pkg::ST_ACCESS)
  );

  // A peripheral must stay selected for the whole enable phase
  a_sel_during_enable: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    bus.penable |-> bus.sel_valid
  );

endmodule

//--- src/apb_addr_map.sv
// APB peripheral address map
module apb_addr_map #(
  parameter int                 NUM_SLAVES = ahb_apb_pkg::DEF_NUM_SLAVES,
  parameter ahb_apb_pkg::addr_t BASE_ADDR  = ahb_apb_pkg::DEF_BASE_ADDR,
  parameter int                 SLOT_BITS  = ahb_apb_pkg::DEF_SLOT_BITS
) (
  input  ahb_apb_pkg::addr_t      haddr,
  output logic                    hit,
  output ahb_apb_pkg::slave_idx_t idx
);

  // ------------------------------
  // Slot arithmetic
  // ------------------------------
  ahb_apb_pkg::addr_t offset;
  ahb_apb_pkg::addr_t slot;
  logic               above_base;
  logic               slot_in_map;

  // Offset from the start of the APB window
  assign offset = haddr - BASE_ADDR;

  // Slot number is everything above the in-slot bits
  assign slot = offset >> SLOT_BITS;

  // Below the base the subtraction wraps, so test it apart
  assign above_base = (haddr >= BASE_ADDR);

  assign slot_in_map = (slot < ahb_apb_pkg::addr_t'(NUM_SLAVES));

  // ------------------------------
  // Decode result
  // ------------------------------
  // Address only; transfer type is qualified in the sequencer
  assign hit = above_base && slot_in_map;

  // Upper slot bits are zero whenever hit is set
  assign idx = ahb_apb_pkg::slave_idx_t'(slot);

endmodule

//--- src/apb_bus_if.sv
// APB request and response bundle
interface apb_bus_if #(
  parameter int NUM_SLAVES = ahb_apb_pkg::DEF_NUM_SLAVES
);

  // Request side, driven by the sequencer
  ahb_apb_pkg::addr_t      paddr;
  logic                    pwrite;
  logic                    penable;
  ahb_apb_pkg::slave_idx_t sel_idx;
  logic                    sel_valid;

  // Response side, muxed from the selected peripheral
  logic                    pready;
  ahb_apb_pkg::data_t      prdata;

  // Index is valid and points at a fitted peripheral
  logic                    lane_valid;

  assign lane_valid = sel_valid && (int'(sel_idx) < NUM_SLAVES);

  modport master (
    output paddr, pwrite, penable, sel_idx, sel_valid,
    input  pready, prdata
  );

  modport fanout (
    input  sel_idx, lane_valid,
    output pready, prdata
  );

endinterface

//--- src/ahb_apb_pkg.sv
// AHB to APB bridge shared types
package ahb_apb_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int MAX_SLAVES = 16;

  typedef logic [ADDR_W-1:0]             addr_t;
  typedef logic [DATA_W-1:0]             data_t;
  typedef logic [$clog2(MAX_SLAVES)-1:0] slave_idx_t;

  // ------------------------------
  // Default address map
  // ------------------------------
  // Slots are contiguous, 2**SLOT_BITS bytes each
  localparam int    DEF_NUM_SLAVES = 4;
  localparam addr_t DEF_BASE_ADDR  = 32'h0080_0000;
  localparam int    DEF_SLOT_BITS  = 16;

  // AHB htrans encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // APB sequencer states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_SETUP  = 2'b01,
    ST_ACCESS = 2'b10
  } apb_state_e;

endpackage
